// ==== sources.f ====
+incdir+verification
rtl/vslide_pkg.sv
rtl/vector_regfile.sv
rtl/vector_slide.sv
rtl/slide_sequencer.sv
rtl/vslide_top.sv
verification/tb_vslide.sv

// ==== Makefile ====
TOP = tb_vslide

.PHONY: compile run clean

compile:
	verilator --binary --timing --top-module $(TOP) -f sources.f --Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "RESULT: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verification/slide_ref_model.svh ====
`ifndef SLIDE_REF_MODEL_SVH
`define SLIDE_REF_MODEL_SVH

// ********************
// random source
// ********************

// 16-bit Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
        n = n ^ 16'hB400;
    end
    return n;
endfunction

// ********************
// expected slide result
// ********************

function automatic void slide_expect(input  vslide_pkg::slide_cmd_t c,
                                     input  logic [VLEN-1:0]        old_rf [32],
                                     output logic [VLEN-1:0]        new_rf [32]);
    logic [31:0]     elem [64];
    logic [31:0]     mask;
    logic [31:0]     val;
    logic [VLEN-1:0] word;
    logic [4:0]      a;
    int              ew;
    int              per;
    int              total;
    int              vl;
    int              idx;
    ew     = 8 << int'(c.vsew);
    per    = VLEN / ew;                         // elements per register
    total  = per << int'(c.vlmul);
    vl     = int'(c.vl);
    mask   = (ew == 32) ? 32'hffff_ffff : (32'd1 << ew) - 32'd1;
    new_rf = old_rf;
    for (int j = 0; j < total; j++) begin       // flatten the source group
        a       = c.vs2 + 5'(j / per);
        elem[j] = 32'(old_rf[a] >> ((j % per) * ew)) & mask;
    end
    for (int r = 0; r < total / per; r++) begin
        word = '0;
        for (int i = 0; i < per; i++) begin
            idx = r * per + i;
            if (idx >= vl) begin
                val = elem[idx];                // tail keeps the source
            end else if (c.op == vslide_pkg::VSLIDE1UP) begin
                if (idx == 0) begin
                    val = c.scalar & mask;
                end else begin
                    val = elem[idx - 1];
                end
            end else if (idx == vl - 1) begin
                val = c.scalar & mask;
            end else begin
                val = elem[idx + 1];
            end
            word = word | (VLEN'(val) << (i * ew));
        end
        new_rf[c.vd + 5'(r)] = word;
    end
endfunction

`endif

// ==== verification/tb_vslide.sv ====
`default_nettype none

module tb_vslide;

    localparam int VLEN         = 64;
    localparam int NREGS        = 32;
    localparam int VL_W         = vslide_pkg::VL_W;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 5;
    localparam int LMUL_MAX     = 8;
    localparam int NUM_TESTS    = 36;
    localparam int DONE_LIMIT   = LMUL_MAX + 12;        // cycles to wait for one done
    // load, run and two-cycle reads of one group, plus slack
    localparam int TEST_CYCLES  = 4 * LMUL_MAX + 16;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * TEST_CYCLES + RESET_CYCLES + 2 * NREGS;

    `include "slide_ref_model.svh"

    logic                   clk;
    logic                   reset_n;
    vslide_pkg::slide_cmd_t cmd;
    logic                   cmd_valid;
    logic                   cmd_ready;
    logic                   done;
    logic                   host_we;
    logic [4:0]             host_addr;
    logic [VLEN-1:0]        host_wdata;
    logic [4:0]             host_raddr;
    logic [VLEN-1:0]        host_rdata;

    logic [VLEN-1:0] shadow [NREGS];        // expected register file contents
    logic [15:0]     lfsr_state;
    int              errors;
    int              pass_count;
    int              fail_count;
    int              test_num;

    logic            in_flight;             // handshake monitor state
    int              since_accept;
    int              exp_latency;

    vslide_top #(
        .VLEN (VLEN)
    ) u_dut (
        .clk        (clk),
        .reset_n    (reset_n),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .done       (done),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_raddr (host_raddr),
        .host_rdata (host_rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v          = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // ********************
    // handshake monitor
    // ********************

    // done is sampled lmul+2 edges after the accepting edge
    always @(posedge clk) begin : handshake_monitor
        if (reset_n) begin
            if (in_flight) begin
                since_accept = since_accept + 1;
                if (cmd_ready !== (since_accept == exp_latency)) begin
                    $display("FAILED cmd_ready: expected 0x%h, got 0x%h at edge %0d",
                             since_accept == exp_latency, cmd_ready, since_accept);
                    errors++;
                end
                if (done) begin
                    if (since_accept != exp_latency) begin
                        $display("done came %0d edges after acceptance, not %0d",
                                 since_accept, exp_latency);
                        errors++;
                    end
                    in_flight = 1'b0;
                end else if (since_accept == exp_latency) begin
                    $display("done missing %0d edges after acceptance", exp_latency);
                    errors++;
                    in_flight = 1'b0;
                end
            end else if (done) begin        // also catches a pulse longer than one cycle
                $display("done pulsed with no command in flight");
                errors++;
            end
            if (cmd_valid && cmd_ready) begin
                in_flight    = 1'b1;
                since_accept = 0;
                exp_latency  = (1 << int'(cmd.vlmul)) + 2;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("the run timed out before all tests finished");
        $display("RESULT: FAIL");
        $finish;
    end

    // ********************
    // bus tasks
    // ********************

    task automatic host_write(input logic [4:0] a, input logic [VLEN-1:0] d);
        @(posedge clk);
        host_we    <= 1'b1;
        host_addr  <= a;
        host_wdata <= d;
        shadow[a]   = d;
    endtask

    task automatic host_read(input logic [4:0] a, output logic [VLEN-1:0] d);
        @(posedge clk);
        host_raddr <= a;
        @(posedge clk);
        d = host_rdata;
    endtask

    task automatic fill_group(input logic [4:0] base, input int n);
        for (int r = 0; r < n; r++) begin
            host_write(base + 5'(r), VLEN'(rand_bits(VLEN)));
        end
        @(posedge clk);
        host_we <= 1'b0;
    endtask

    task automatic issue_cmd(input vslide_pkg::slide_cmd_t c);
        @(posedge clk);
        cmd       <= c;
        cmd_valid <= 1'b1;
        @(posedge clk);
        while (!cmd_ready) begin
            @(posedge clk);
        end
        cmd_valid <= 1'b0;                  // accepted at this edge
    endtask

    task automatic wait_done();
        int   n;
        logic got;
        n   = 0;
        got = 1'b0;
        while (!got && n < DONE_LIMIT) begin
            @(posedge clk);
            got = done;
            n++;
        end
        if (!got) begin
            $display("no done pulse within %0d cycles of the command", DONE_LIMIT);
            errors++;
        end
    endtask

    // ********************
    // checking
    // ********************

    task automatic apply_cmd(input vslide_pkg::slide_cmd_t c);
        logic [VLEN-1:0] next_rf [NREGS];
        slide_expect(c, shadow, next_rf);
        shadow = next_rf;
    endtask

    task automatic check_regs(input logic [4:0] base, input int n);
        logic [VLEN-1:0] got;
        logic [4:0]      a;
        for (int r = 0; r < n; r++) begin
            a = base + 5'(r);
            host_read(a, got);
            if (got !== shadow[a]) begin
                $display("FAILED host_rdata v%0d: expected 0x%h, got 0x%h", a, shadow[a], got);
                errors++;
            end
        end
    endtask

    task automatic report(input string name, input int errs0);
        test_num++;
        if (errors == errs0) begin
            pass_count++;
            $display("test %0d %s: ok", test_num, name);
        end else begin
            fail_count++;
            $display("test %0d %s: %0d errors", test_num, name, errors - errs0);
        end
    endtask

    // ********************
    // tests
    // ********************

    task automatic reset_test();
        int errs0;
        errs0 = errors;
        @(posedge clk);
        if (cmd_ready !== 1'b1) begin
            $display("FAILED cmd_ready: expected 0x1, got 0x%h", cmd_ready);
            errors++;
        end
        if (done !== 1'b0) begin
            $display("FAILED done: expected 0x0, got 0x%h", done);
            errors++;
        end
        check_regs(5'd0, NREGS);            // shadow is all zero here
        report("reset state", errs0);
    endtask

    task automatic slide_test(input string name, input vslide_pkg::slide_op_e op,
                              input vslide_pkg::vew_e ew, input vslide_pkg::vlmul_e lm,
                              input logic short_vl);
        vslide_pkg::slide_cmd_t c;
        int nregs;
        int max_vl;
        int errs0;
        errs0   = errors;
        nregs   = 1 << int'(lm);
        max_vl  = (VLEN >> (3 + int'(ew))) * nregs;
        c.op    = op;
        c.vsew  = ew;
        c.vlmul = lm;
        if (short_vl) begin
            c.vl = VL_W'(1 + int'(rand_bits(6)) % (max_vl - 1));
        end else begin
            c.vl = VL_W'(max_vl);
        end
        c.vs2    = 5'(rand_bits(5));
        c.vd     = c.vs2 + 5'd8 + 5'(rand_bits(3));     // disjoint from the source group
        c.scalar = 32'(rand_bits(32));
        fill_group(c.vs2, nregs);
        issue_cmd(c);
        wait_done();
        apply_cmd(c);
        check_regs(c.vd, nregs);
        report($sformatf("%s vl=%0d vs2=v%0d vd=v%0d", name, c.vl, c.vs2, c.vd), errs0);
    endtask

    task automatic handshake_test();
        vslide_pkg::slide_cmd_t cmd_a;
        vslide_pkg::slide_cmd_t cmd_b;
        logic [4:0]             base;
        int                     errs0;
        errs0        = errors;
        base         = 5'(rand_bits(5));
        cmd_a.op     = vslide_pkg::VSLIDE1DOWN;
        cmd_a.vsew   = vslide_pkg::EW16;
        cmd_a.vlmul  = vslide_pkg::LMUL_4;
        cmd_a.vl     = VL_W'(16);
        cmd_a.vs2    = base;
        cmd_a.vd     = base + 5'd8;
        cmd_a.scalar = 32'(rand_bits(32));
        cmd_b.op     = vslide_pkg::VSLIDE1UP;
        cmd_b.vsew   = vslide_pkg::EW8;
        cmd_b.vlmul  = vslide_pkg::LMUL_2;
        cmd_b.vl     = VL_W'(16);
        cmd_b.vs2    = base + 5'd16;
        cmd_b.vd     = base + 5'd24;
        cmd_b.scalar = 32'(rand_bits(32));
        fill_group(cmd_a.vs2, 4);
        fill_group(cmd_b.vs2, 2);
        issue_cmd(cmd_a);
        cmd       <= cmd_b;                 // held valid while the first one runs
        cmd_valid <= 1'b1;
        @(posedge clk);
        while (!cmd_ready) begin
            @(posedge clk);
        end
        if (!done) begin
            $display("second command was accepted before the first one finished");
            errors++;
        end
        cmd_valid <= 1'b0;
        wait_done();
        apply_cmd(cmd_a);
        apply_cmd(cmd_b);
        check_regs(cmd_a.vd, 4);
        check_regs(cmd_b.vd, 2);
        report("back-to-back commands", errs0);
    endtask

    task automatic host_during_run_test();
        vslide_pkg::slide_cmd_t c;
        logic [VLEN-1:0]        data;
        logic [4:0]             other;
        int                     errs0;
        errs0    = errors;
        c.op     = vslide_pkg::VSLIDE1DOWN;
        c.vsew   = vslide_pkg::EW32;
        c.vlmul  = vslide_pkg::LMUL_2;
        c.vl     = VL_W'(4);
        c.vs2    = 5'(rand_bits(5));
        c.vd     = c.vs2 + 5'd8;
        c.scalar = 32'(rand_bits(32));
        other    = c.vs2 + 5'd30;
        data     = VLEN'(rand_bits(VLEN));
        fill_group(c.vs2, 2);
        issue_cmd(c);
        host_we    <= 1'b1;                 // lands before the first write back
        host_addr  <= other;
        host_wdata <= data;
        shadow[other] = data;
        @(posedge clk);
        host_addr  <= c.vd;                 // same cycle as the sequencer write to vd
        host_wdata <= ~data;
        @(posedge clk);
        host_we <= 1'b0;
        wait_done();
        apply_cmd(c);
        check_regs(c.vd, 2);
        check_regs(other, 1);
        report("host writes during a run", errs0);
    endtask

    // ********************
    // main sequence
    // ********************

    initial begin : stimulus
        vslide_pkg::slide_op_e op;
        clk          = 1'b0;
        reset_n      = 1'b0;
        cmd          = '0;
        cmd_valid    = 1'b0;
        host_we      = 1'b0;
        host_addr    = '0;
        host_wdata   = '0;
        host_raddr   = '0;
        lfsr_state   = 16'd56;
        errors       = 0;
        pass_count   = 0;
        fail_count   = 0;
        test_num     = 0;
        in_flight    = 1'b0;
        since_accept = 0;
        exp_latency  = 0;
        for (int r = 0; r < NREGS; r++) begin
            shadow[r] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
        reset_test();
        for (int e = 0; e < 3; e++) begin
            slide_test("slide-up lmul1", vslide_pkg::VSLIDE1UP,
                       vslide_pkg::vew_e'(2'(e)), vslide_pkg::LMUL_1, 1'b0);
        end
        for (int l = 1; l < 4; l++) begin
            for (int e = 0; e < 3; e++) begin
                slide_test($sformatf("slide-down lmul%0d", 1 << l), vslide_pkg::VSLIDE1DOWN,
                           vslide_pkg::vew_e'(2'(e)), vslide_pkg::vlmul_e'(2'(l)), 1'b0);
                slide_test($sformatf("slide-up lmul%0d", 1 << l), vslide_pkg::VSLIDE1UP,
                           vslide_pkg::vew_e'(2'(e)), vslide_pkg::vlmul_e'(2'(l)), 1'b0);
            end
        end
        for (int t = 0; t < 12; t++) begin
            op = vslide_pkg::slide_op_e'(1'(rand_bits(1)));
            slide_test("random short vl", op, vslide_pkg::vew_e'(2'(int'(rand_bits(2)) % 3)),
                       vslide_pkg::vlmul_e'(2'(rand_bits(2))), 1'b1);
        end
        handshake_test();
        host_during_run_test();
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/vslide_top.sv ====
`default_nettype none

module vslide_top #(
    parameter int VLEN = 64
) (
    input  logic                    clk,
    input  logic                    reset_n,

    // command port
    input  vslide_pkg::slide_cmd_t  cmd,
    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    output logic                    done,

    // host access to the register file
    input  logic                    host_we,
    input  logic [4:0]              host_addr,
    input  logic [VLEN-1:0]         host_wdata,
    input  logic [4:0]              host_raddr,
    output logic [VLEN-1:0]         host_rdata
);

    logic [4:0]                   rd_addr_a;
    logic [4:0]                   rd_addr_b;
    logic [VLEN-1:0]              rd_data_a;
    logic [VLEN-1:0]              rd_data_b;
    logic                         seq_we;
    logic [4:0]                   seq_waddr;
    logic [VLEN-1:0]              seq_wdata;

    vslide_pkg::slide_op_e        slide_op;
    vslide_pkg::vew_e             vsew;
    logic [31:0]                  scalar;
    logic [VLEN-1:0]              src;
    logic [31:0]                  next_elem;
    logic [vslide_pkg::VL_W-1:0]  chunk_vl;
    logic                         first_chunk;
    logic                         last_chunk;
    logic                         step;
    logic [VLEN-1:0]              result;

    vector_regfile #(
        .VLEN (VLEN)
    ) u_regfile (
        .clk        (clk),
        .reset_n    (reset_n),
        .rd_addr_a  (rd_addr_a),
        .rd_data_a  (rd_data_a),
        .rd_addr_b  (rd_addr_b),
        .rd_data_b  (rd_data_b),
        .seq_we     (seq_we),
        .seq_waddr  (seq_waddr),
        .seq_wdata  (seq_wdata),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata)
    );

    slide_sequencer #(
        .VLEN (VLEN)
    ) u_seq (
        .clk         (clk),
        .reset_n     (reset_n),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .done        (done),
        .rd_addr_a   (rd_addr_a),
        .rd_addr_b   (rd_addr_b),
        .host_raddr  (host_raddr),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .slide_op    (slide_op),
        .vsew        (vsew),
        .scalar      (scalar),
        .src         (src),
        .next_elem   (next_elem),
        .chunk_vl    (chunk_vl),
        .first_chunk (first_chunk),
        .last_chunk  (last_chunk),
        .step        (step),
        .result      (result),
        .seq_we      (seq_we),
        .seq_waddr   (seq_waddr),
        .seq_wdata   (seq_wdata)
    );

    vector_slide #(
        .VLEN (VLEN)
    ) u_slide (
        .clk         (clk),
        .reset_n     (reset_n),
        .slide_op    (slide_op),
        .vsew        (vsew),
        .src         (src),
        .next_elem   (next_elem),
        .scalar      (scalar),
        .chunk_vl    (chunk_vl),
        .first_chunk (first_chunk),
        .last_chunk  (last_chunk),
        .step        (step),
        .result      (result)
    );

    assign host_rdata = rd_data_b;      // port b follows host_raddr while idle

endmodule

`default_nettype wire

// ==== rtl/slide_sequencer.sv ====
`default_nettype none

module slide_sequencer #(
    parameter int VLEN = 64
) (
    input  logic                         clk,
    input  logic                         reset_n,

    // command port
    input  vslide_pkg::slide_cmd_t       cmd,
    input  logic                         cmd_valid,
    output logic                         cmd_ready,
    output logic                         done,

    // register file reads
    output logic [4:0]                   rd_addr_a,
    output logic [4:0]                   rd_addr_b,
    input  logic [4:0]                   host_raddr,
    input  logic [VLEN-1:0]              rd_data_a,
    input  logic [VLEN-1:0]              rd_data_b,

    // slide unit
    output vslide_pkg::slide_op_e        slide_op,
    output vslide_pkg::vew_e             vsew,
    output logic [31:0]                  scalar,
    output logic [VLEN-1:0]              src,
    output logic [31:0]                  next_elem,
    output logic [vslide_pkg::VL_W-1:0]  chunk_vl,
    output logic                         first_chunk,
    output logic                         last_chunk,
    output logic                         step,
    input  logic [VLEN-1:0]              result,

    // register file write
    output logic                         seq_we,
    output logic [4:0]                   seq_waddr,
    output logic [VLEN-1:0]              seq_wdata
);

    localparam int VL_W   = vslide_pkg::VL_W;
    localparam int CNT_W  = VL_W + 1;       // room for offset + chunk size
    localparam int ELEMS8 = VLEN / 8;       // elements per register at EW8

    vslide_pkg::seq_state_e state_q;
    vslide_pkg::slide_cmd_t cmd_q;

    logic [2:0]       k_q;                  // register index within the group
    logic [2:0]       lmul_last;
    logic             wr_valid_q;
    logic [4:0]       wr_addr_q;
    logic             done_q;

    logic [CNT_W-1:0] elems_per;
    logic [CNT_W-1:0] offset;
    logic [CNT_W-1:0] vl_ext;
    logic [CNT_W-1:0] remain;

    // ********************
    // control FSM
    // ********************

    assign lmul_last = 3'((4'd1 << cmd_q.vlmul) - 4'd1);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q    <= vslide_pkg::IDLE;
            cmd_q      <= '0;
            k_q        <= '0;
            wr_valid_q <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            wr_valid_q <= (state_q == vslide_pkg::RUN);     // result lands next cycle
            done_q     <= (state_q == vslide_pkg::DRAIN);
            case (state_q)
                vslide_pkg::IDLE: begin
                    if (cmd_valid) begin
                        cmd_q   <= cmd;
                        k_q     <= '0;
                        state_q <= vslide_pkg::RUN;
                    end
                end
                vslide_pkg::RUN: begin
                    if (k_q == lmul_last) begin
                        state_q <= vslide_pkg::DRAIN;
                    end else begin
                        k_q <= k_q + 3'd1;
                    end
                end
                default: begin                              // DRAIN, final write
                    state_q <= vslide_pkg::IDLE;
                end
            endcase
        end
    end

    // destination follows the chunk one cycle behind
    always_ff @(posedge clk) begin
        if (step) begin
            wr_addr_q <= cmd_q.vd + 5'(k_q);
        end
    end

    assign cmd_ready = (state_q == vslide_pkg::IDLE);
    assign done      = done_q;
    assign step      = (state_q == vslide_pkg::RUN);

    // ********************
    // chunk length and flags
    // ********************

    assign elems_per = CNT_W'(ELEMS8) >> cmd_q.vsew;
    assign offset    = CNT_W'(k_q) * elems_per;             // first element of chunk k
    assign vl_ext    = CNT_W'(cmd_q.vl);
    assign remain    = (vl_ext > offset) ? vl_ext - offset : '0;

    assign chunk_vl    = (remain > elems_per) ? VL_W'(elems_per) : VL_W'(remain);
    assign first_chunk = (k_q == 3'd0);
    assign last_chunk  = (k_q == lmul_last) || (vl_ext <= offset + elems_per);

    // ********************
    // datapath routing
    // ********************

    assign rd_addr_a = cmd_q.vs2 + 5'(k_q);
    assign rd_addr_b = (state_q == vslide_pkg::IDLE) ? host_raddr
                                                     : cmd_q.vs2 + 5'(k_q) + 5'd1;

    assign slide_op  = cmd_q.op;
    assign vsew      = cmd_q.vsew;
    assign scalar    = cmd_q.scalar;
    assign src       = rd_data_a;
    assign next_elem = rd_data_b[31:0];     // element 0 of the next register

    assign seq_we    = wr_valid_q;
    assign seq_waddr = wr_addr_q;
    assign seq_wdata = result;

endmodule

`default_nettype wire

// ==== rtl/vector_slide.sv ====
`default_nettype none

module vector_slide #(
    parameter int VLEN = 64
) (
    input  logic                         clk,
    input  logic                         reset_n,

    input  vslide_pkg::slide_op_e        slide_op,
    input  vslide_pkg::vew_e             vsew,
    input  logic [VLEN-1:0]              src,
    input  logic [31:0]                  next_elem,   // element 0 of the next register
    input  logic [31:0]                  scalar,
    input  logic [vslide_pkg::VL_W-1:0]  chunk_vl,    // active elements in this chunk
    input  logic                         first_chunk,
    input  logic                         last_chunk,
    input  logic                         step,

    output logic [VLEN-1:0]              result
);

    logic [31:0]     carry_q;       // top element of the previous chunk
    logic [VLEN-1:0] down_sel;
    logic [VLEN-1:0] up_sel;
    logic [VLEN-1:0] result_q;

    // ********************
    // per-width element logic
    // ********************

    for (genvar g = 0; g < 3; g++) begin : g_ew
        localparam int EW = 8 << g;
        localparam int NE = VLEN / EW;

        logic [VLEN-1:0] down_shift;
        logic [VLEN-1:0] up_shift;
        logic [VLEN-1:0] down_res;
        logic [VLEN-1:0] up_res;

        assign down_shift = src >> EW;      // element i holds src element i+1
        assign up_shift   = src << EW;      // element i holds src element i-1

        // slide down
        always_comb begin
            for (int i = 0; i < NE; i++) begin
                if (i + 1 < chunk_vl) begin
                    down_res[EW*i +: EW] = down_shift[EW*i +: EW];
                end else if (i + 1 == chunk_vl) begin   // last active element
                    if (last_chunk) begin
                        down_res[EW*i +: EW] = scalar[EW-1:0];
                    end else begin
                        down_res[EW*i +: EW] = next_elem[EW-1:0];
                    end
                end else begin                          // tail
                    down_res[EW*i +: EW] = src[EW*i +: EW];
                end
            end
        end

        // slide up
        always_comb begin
            for (int i = 0; i < NE; i++) begin
                if (i < chunk_vl) begin
                    if (i == 0) begin
                        if (first_chunk) begin
                            up_res[EW*i +: EW] = scalar[EW-1:0];
                        end else begin
                            up_res[EW*i +: EW] = carry_q[EW-1:0];
                        end
                    end else begin
                        up_res[EW*i +: EW] = up_shift[EW*i +: EW];
                    end
                end else begin                          // tail
                    up_res[EW*i +: EW] = src[EW*i +: EW];
                end
            end
        end
    end

    // ********************
    // carry for slide up
    // ********************

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            carry_q <= '0;
        end else if (step) begin
            case (vsew)
                vslide_pkg::EW8: begin
                    carry_q <= {24'd0, src[VLEN-1 -: 8]};
                end
                vslide_pkg::EW16: begin
                    carry_q <= {16'd0, src[VLEN-1 -: 16]};
                end
                default: begin
                    carry_q <= src[VLEN-1 -: 32];
                end
            endcase
        end
    end

    // ********************
    // width select and result
    // ********************

    always_comb begin
        case (vsew)
            vslide_pkg::EW8: begin
                down_sel = g_ew[0].down_res;
                up_sel   = g_ew[0].up_res;
            end
            vslide_pkg::EW16: begin
                down_sel = g_ew[1].down_res;
                up_sel   = g_ew[1].up_res;
            end
            default: begin
                down_sel = g_ew[2].down_res;
                up_sel   = g_ew[2].up_res;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (slide_op == vslide_pkg::VSLIDE1DOWN) begin
            result_q <= down_sel;
        end else begin
            result_q <= up_sel;
        end
    end

    assign result = result_q;

endmodule

`default_nettype wire

// ==== rtl/vector_regfile.sv ====
`default_nettype none

module vector_regfile #(
    parameter int VLEN = 64
) (
    input  logic            clk,
    input  logic            reset_n,

    // read ports, combinational
    input  logic [4:0]      rd_addr_a,
    output logic [VLEN-1:0] rd_data_a,
    input  logic [4:0]      rd_addr_b,
    output logic [VLEN-1:0] rd_data_b,

    // sequencer write
    input  logic            seq_we,
    input  logic [4:0]      seq_waddr,
    input  logic [VLEN-1:0] seq_wdata,

    // host write
    input  logic            host_we,
    input  logic [4:0]      host_addr,
    input  logic [VLEN-1:0] host_wdata
);

    localparam int NREGS = 32;

    logic [VLEN-1:0] regs [NREGS];

    // ********************
    // write port
    // ********************

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int r = 0; r < NREGS; r++) begin
                regs[r] <= '0;
            end
        end else if (seq_we) begin          // sequencer has priority
            regs[seq_waddr] <= seq_wdata;
        end else if (host_we) begin
            regs[host_addr] <= host_wdata;
        end
    end

    // ********************
    // read ports
    // ********************

    // 5-bit addresses wrap the group index modulo 32 on their own
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];     // shared with host reads when idle

endmodule

`default_nettype wire

// ==== rtl/vslide_pkg.sv ====
`default_nettype none

package vslide_pkg;

    // ********************
    // sizes
    // ********************

    // vl counts up to LMUL*VLEN/SEW = 8*64/8 = 64, so VLEN must not exceed 64
    localparam int VL_W = 7;

    // ********************
    // encodings
    // ********************

    typedef enum logic [1:0] {
        EW8  = 2'b00,   // 8-bit elements
        EW16 = 2'b01,   // 16-bit elements
        EW32 = 2'b10    // 32-bit elements
    } vew_e;

    typedef enum logic [1:0] {
        LMUL_1 = 2'b00,
        LMUL_2 = 2'b01,
        LMUL_4 = 2'b10,
        LMUL_8 = 2'b11
    } vlmul_e;

    typedef enum logic {
        VSLIDE1UP   = 1'b0,
        VSLIDE1DOWN = 1'b1
    } slide_op_e;

    // ********************
    // command
    // ********************

    typedef struct packed {
        slide_op_e        op;
        vew_e             vsew;
        vlmul_e           vlmul;
        logic [VL_W-1:0]  vl;      // active elements over the whole group
        logic [4:0]       vs2;     // first source register
        logic [4:0]       vd;      // first destination register
        logic [31:0]      scalar;  // value shifted in at the open end
    } slide_cmd_t;

    // sequencer FSM
    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        RUN   = 2'b01,
        DRAIN = 2'b10
    } seq_state_e;

endpackage

`default_nettype wire
